/* verilog/sata_prim_pkg.sv */
////////////////////
// SATA primitive definitions
// Dword and K-character mask types
// ALIGN and SYNC primitive values
// Transmit dword struct for the transceiver
////////////////////

package sata_prim_pkg;

  ////////////////////
  // Types
  ////////////////////

  // One dword on the transceiver data path
  typedef logic [31:0] dword_t;

  // One bit per byte, set for a K character
  typedef logic [3:0] charisk_t;

  ////////////////////
  // Primitive values
  ////////////////////

  // ALIGN, K28.5 D10.2 D10.2 D27.3
  localparam dword_t ALIGN_VAL = 32'h7B4A4ABC;

  // SYNC, K28.3 D21.4 D21.5 D21.5
  localparam dword_t SYNC_VAL = 32'hB5B5957C;

  // Primitives carry the K character in byte 0 only
  localparam charisk_t PRIM_CHARISK = 4'b0001;

  ////////////////////
  // Transmit word
  ////////////////////

  // Data with its K mask, 36 bits
  typedef struct packed {
    dword_t   data;
    charisk_t charisk;
  } tx_dword_t;

endpackage

/* verilog/sata_oob_pkg.sv */
////////////////////
// SATA OOB signalling definitions
// COM type, OOB cycle counter type
// Detect and transmit request structs
// Device PHY control state encoding
////////////////////

package sata_oob_pkg;

  ////////////////////
  // OOB sequence shape
  ////////////////////

  // Bursts per COM train
  localparam int OOB_BURSTS = 6;

  // Consecutive good gaps before a COM is recognised
  localparam int OOB_MATCH = 4;

  // Cycle count for bursts and gaps
  typedef logic [15:0] oob_cnt_t;

  // COMINIT and COMRESET share timing
  typedef enum logic {
    COM_INIT = 1'b0,
    COM_WAKE = 1'b1
  } com_type_e;

  ////////////////////
  // Internal buses
  ////////////////////

  // Detector to control block
  typedef struct packed {
    logic comreset_det;  // one cycle strobe
    logic comwake_det;   // level until line idle
  } oob_det_t;

  // Control block to burst generator
  typedef struct packed {
    logic      strt;
    com_type_e com_type;
  } com_req_t;

  // Device PHY bring-up states
  typedef enum logic [3:0] {
    DP1_RESET             = 4'd0,
    DP2_COMINIT           = 4'd1,
    DP3_AWAIT_COMWAKE     = 4'd2,
    DP3B_AWAIT_NO_COMWAKE = 4'd3,
    DP4_CALIBRATE         = 4'd4,
    DP5_COMWAKE           = 4'd5,
    DP6_SEND_ALIGN        = 4'd6,
    DP7_READY             = 4'd7,
    DP11_ERROR            = 4'd8
  } dev_state_e;

endpackage

/* verilog/sata_oob_detect.sv */
////////////////////
// OOB receive detector
// Measures squelch gaps between bursts
// COMRESET strobe and COMWAKE level out
////////////////////

`timescale 1ns/10ps

module sata_oob_detect #(
  parameter int GAP_INIT = 24,
  parameter int GAP_WAKE = 8,
  parameter int GAP_TOL  = 2
) (
  input  logic                   clk_phy,
  input  logic                   rst_n,
  input  logic                   rx_oob_i,
  output sata_oob_pkg::oob_det_t det_o
);

  // Gap windows in cycles
  localparam sata_oob_pkg::oob_cnt_t INIT_MIN = sata_oob_pkg::oob_cnt_t'(GAP_INIT - GAP_TOL);
  localparam sata_oob_pkg::oob_cnt_t INIT_MAX = sata_oob_pkg::oob_cnt_t'(GAP_INIT + GAP_TOL);
  localparam sata_oob_pkg::oob_cnt_t WAKE_MIN = sata_oob_pkg::oob_cnt_t'(GAP_WAKE - GAP_TOL);
  localparam sata_oob_pkg::oob_cnt_t WAKE_MAX = sata_oob_pkg::oob_cnt_t'(GAP_WAKE + GAP_TOL);

  logic                    rx_oob_q;
  logic                    gap_open;
  sata_oob_pkg::oob_cnt_t  gap_cnt;
  logic [2:0]              match_cnt;
  logic [2:0]              match_nxt;
  sata_oob_pkg::com_type_e match_kind;
  sata_oob_pkg::com_type_e gap_kind;
  logic                    rise;
  logic                    fall;
  logic                    is_init;
  logic                    is_wake;
  logic                    match_hit;
  logic                    line_idle;
  logic                    comreset_q;
  logic                    comwake_q;

  ////////////////////
  // Gap classification
  ////////////////////

  always_comb begin
    rise     = rx_oob_i & ~rx_oob_q;
    fall     = ~rx_oob_i & rx_oob_q;
    is_init  = (gap_cnt >= INIT_MIN) && (gap_cnt <= INIT_MAX);
    is_wake  = (gap_cnt >= WAKE_MIN) && (gap_cnt <= WAKE_MAX);
    // Windows do not overlap
    gap_kind = is_init ? sata_oob_pkg::COM_INIT : sata_oob_pkg::COM_WAKE;
    // Continue the run only for the same kind
    if ((match_cnt != 3'd0) && (match_kind == gap_kind)) begin
      match_nxt = match_cnt + 3'd1;
    end else begin
      match_nxt = 3'd1;
    end
    match_hit = rise && gap_open && (is_init || is_wake) &&
                (match_nxt == 3'(sata_oob_pkg::OOB_MATCH));
    // Longer than any legal gap
    line_idle = !rx_oob_i && (gap_cnt > INIT_MAX);
  end

  ////////////////////
  // Squelch edge and gap length
  ////////////////////

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      rx_oob_q <= 1'b0;
      gap_open <= 1'b0;
      gap_cnt  <= '0;
    end else begin
      rx_oob_q <= rx_oob_i;
      // Open on burst end, close on next burst start
      if (fall) begin
        gap_open <= 1'b1;
      end else if (rise) begin
        gap_open <= 1'b0;
      end
      // Saturating count of low samples since the last burst
      if (rx_oob_i) begin
        gap_cnt <= '0;
      end else if (gap_cnt != '1) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // Match run and detect outputs
  ////////////////////

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      match_cnt  <= '0;
      match_kind <= sata_oob_pkg::COM_INIT;
      comreset_q <= 1'b0;
      comwake_q  <= 1'b0;
    end else begin
      if (rise && gap_open) begin
        if (is_init || is_wake) begin
          match_kind <= gap_kind;
          match_cnt  <= match_hit ? 3'd0 : match_nxt;
        end else begin
          // Bad gap breaks the run
          match_cnt <= '0;
        end
      end else if (line_idle) begin
        match_cnt <= '0;
      end
      comreset_q <= match_hit && (gap_kind == sata_oob_pkg::COM_INIT);
      // COMWAKE held until the host goes quiet
      if (match_hit && (gap_kind == sata_oob_pkg::COM_WAKE)) begin
        comwake_q <= 1'b1;
      end else if (line_idle) begin
        comwake_q <= 1'b0;
      end
    end
  end

  assign det_o = '{comreset_det: comreset_q, comwake_det: comwake_q};

  // No COMRESET recognised while a COMWAKE is still held
  a_det_exclusive: assert property (@(posedge clk_phy) disable iff (!rst_n)
    !(comreset_q && comwake_q));

endmodule

/* verilog/sata_oob_burst_gen.sv */
////////////////////
// OOB transmit burst generator
// Six-burst COMINIT or COMWAKE train
// Done strobe after the trailing gap
////////////////////

`timescale 1ns/10ps

module sata_oob_burst_gen #(
  parameter int BURST_LEN = 8,
  parameter int GAP_INIT  = 24,
  parameter int GAP_WAKE  = 8
) (
  input  logic                   clk_phy,
  input  logic                   rst_n,
  input  sata_oob_pkg::com_req_t req_i,
  output logic                   tx_oob_o,
  output logic                   done_o
);

  localparam sata_oob_pkg::oob_cnt_t BURST_END = sata_oob_pkg::oob_cnt_t'(BURST_LEN - 1);
  localparam sata_oob_pkg::oob_cnt_t INIT_END  = sata_oob_pkg::oob_cnt_t'(GAP_INIT - 1);
  localparam sata_oob_pkg::oob_cnt_t WAKE_END  = sata_oob_pkg::oob_cnt_t'(GAP_WAKE - 1);

  typedef enum logic [1:0] {
    BG_IDLE,
    BG_BURST,
    BG_GAP
  } bg_state_e;

  bg_state_e               state_q;
  sata_oob_pkg::oob_cnt_t  cyc_cnt;
  sata_oob_pkg::oob_cnt_t  gap_end;
  logic [2:0]              burst_cnt;
  sata_oob_pkg::com_type_e type_q;
  logic                    done_q;

  // Gap spacing by COM kind
  assign gap_end = (type_q == sata_oob_pkg::COM_WAKE) ? WAKE_END : INIT_END;

  // Kind held for the whole train
  always_ff @(posedge clk_phy) begin
    if ((state_q == BG_IDLE) && req_i.strt) begin
      type_q <= req_i.com_type;
    end
  end

  ////////////////////
  // Train sequencer
  ////////////////////

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      state_q   <= BG_IDLE;
      cyc_cnt   <= '0;
      burst_cnt <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        BG_IDLE: begin
          if (req_i.strt) begin
            state_q   <= BG_BURST;
            cyc_cnt   <= '0;
            burst_cnt <= '0;
          end
        end
        BG_BURST: begin
          if (cyc_cnt == BURST_END) begin
            state_q   <= BG_GAP;
            cyc_cnt   <= '0;
            burst_cnt <= burst_cnt + 3'd1;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        BG_GAP: begin
          if (cyc_cnt == gap_end) begin
            cyc_cnt <= '0;
            // Trailing gap after the last burst ends the train
            if (burst_cnt == 3'(sata_oob_pkg::OOB_BURSTS)) begin
              state_q <= BG_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= BG_BURST;
            end
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        default: state_q <= BG_IDLE;
      endcase
    end
  end

  assign tx_oob_o = (state_q == BG_BURST);
  assign done_o   = done_q;

  // Control block only requests between trains
  a_req_when_idle: assert property (@(posedge clk_phy) disable iff (!rst_n)
    req_i.strt |-> (state_q == BG_IDLE));

endmodule

/* verilog/sata_phy_dev_ctrl.sv */
////////////////////
// Device PHY bring-up control
// Reset, COMINIT, COMWAKE, ALIGN, ready
// Retry and ALIGN timeouts
// Transmit dword and idle selection
////////////////////

`timescale 1ns/10ps

module sata_phy_dev_ctrl #(
  parameter int RETRY_CYCLES = 750000,
  parameter int ALIGN_CYCLES = 4095
) (
  input  logic                     clk_phy,
  input  logic                     rst_n,
  input  logic                     gt_rst_done_i,
  input  sata_oob_pkg::oob_det_t   det_i,
  input  sata_prim_pkg::dword_t    rx_data_i,
  input  logic                     com_done_i,
  output sata_oob_pkg::com_req_t   com_req_o,
  output logic                     tx_elec_idle_o,
  output sata_prim_pkg::tx_dword_t tx_o,
  output logic                     link_up_o
);

  localparam int RETRY_W = $clog2(RETRY_CYCLES + 1);
  localparam int ALIGN_W = $clog2(ALIGN_CYCLES + 1);

  sata_oob_pkg::dev_state_e state_q;
  sata_oob_pkg::dev_state_e state_nxt;
  logic [RETRY_W-1:0]       retry_cnt;
  logic [ALIGN_W-1:0]       align_cnt;
  logic                     align_det;
  logic                     com_busy;
  logic                     strt_q;
  sata_oob_pkg::com_type_e  com_type_q;
  logic                     elec_idle_q;
  logic                     link_up_q;
  sata_prim_pkg::tx_dword_t tx_q;

  // States that drive a COM train
  function automatic logic is_com_state(sata_oob_pkg::dev_state_e s);
    return (s == sata_oob_pkg::DP2_COMINIT) || (s == sata_oob_pkg::DP5_COMWAKE);
  endfunction

  // Host ALIGN on already aligned dwords
  assign align_det = (rx_data_i == sata_prim_pkg::ALIGN_VAL);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      // Quiet until the transceiver and generator are ready
      sata_oob_pkg::DP1_RESET: begin
        if (gt_rst_done_i && !com_busy) begin
          state_nxt = sata_oob_pkg::DP2_COMINIT;
        end
      end
      sata_oob_pkg::DP2_COMINIT: begin
        if (com_done_i) begin
          state_nxt = sata_oob_pkg::DP3_AWAIT_COMWAKE;
        end
      end
      sata_oob_pkg::DP3_AWAIT_COMWAKE: begin
        if (det_i.comwake_det) begin
          state_nxt = sata_oob_pkg::DP3B_AWAIT_NO_COMWAKE;
        end else if (retry_cnt == '0) begin
          state_nxt = sata_oob_pkg::DP1_RESET;
        end
      end
      // Host COMWAKE must end before we answer
      sata_oob_pkg::DP3B_AWAIT_NO_COMWAKE: begin
        if (!det_i.comwake_det) begin
          state_nxt = sata_oob_pkg::DP4_CALIBRATE;
        end
      end
      sata_oob_pkg::DP4_CALIBRATE: state_nxt = sata_oob_pkg::DP5_COMWAKE;
      sata_oob_pkg::DP5_COMWAKE: begin
        if (com_done_i) begin
          state_nxt = sata_oob_pkg::DP6_SEND_ALIGN;
        end
      end
      sata_oob_pkg::DP6_SEND_ALIGN: begin
        if (align_det) begin
          state_nxt = sata_oob_pkg::DP7_READY;
        end else if (align_cnt == '0) begin
          state_nxt = sata_oob_pkg::DP11_ERROR;
        end
      end
      sata_oob_pkg::DP7_READY: state_nxt = sata_oob_pkg::DP7_READY;
      sata_oob_pkg::DP11_ERROR: state_nxt = sata_oob_pkg::DP1_RESET;
      default: state_nxt = sata_oob_pkg::DP1_RESET;
    endcase
    // Host COMRESET wins from any state
    if (det_i.comreset_det) begin
      state_nxt = sata_oob_pkg::DP1_RESET;
    end
  end

  ////////////////////
  // State, timeouts, COM request
  ////////////////////

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      state_q    <= sata_oob_pkg::DP1_RESET;
      retry_cnt  <= RETRY_W'(RETRY_CYCLES);
      align_cnt  <= ALIGN_W'(ALIGN_CYCLES);
      strt_q     <= 1'b0;
      com_type_q <= sata_oob_pkg::COM_INIT;
      com_busy   <= 1'b0;
    end else begin
      state_q <= state_nxt;
      // Count down only in the waiting state
      if (state_q == sata_oob_pkg::DP3_AWAIT_COMWAKE) begin
        retry_cnt <= retry_cnt - 1'b1;
      end else begin
        retry_cnt <= RETRY_W'(RETRY_CYCLES);
      end
      if (state_q == sata_oob_pkg::DP6_SEND_ALIGN) begin
        align_cnt <= align_cnt - 1'b1;
      end else begin
        align_cnt <= ALIGN_W'(ALIGN_CYCLES);
      end
      // One entry strobe per COM state visit
      strt_q <= is_com_state(state_nxt) && !is_com_state(state_q);
      if (state_nxt == sata_oob_pkg::DP5_COMWAKE) begin
        com_type_q <= sata_oob_pkg::COM_WAKE;
      end else if (state_nxt == sata_oob_pkg::DP2_COMINIT) begin
        com_type_q <= sata_oob_pkg::COM_INIT;
      end
      // Train in flight can outlive an aborted COM state
      if (strt_q) begin
        com_busy <= 1'b1;
      end else if (com_done_i) begin
        com_busy <= 1'b0;
      end
    end
  end

  assign com_req_o = '{strt: strt_q, com_type: com_type_q};

  ////////////////////
  // Line outputs
  ////////////////////

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      elec_idle_q <= 1'b1;
      link_up_q   <= 1'b0;
      tx_q        <= '0;
    end else begin
      link_up_q <= (state_q == sata_oob_pkg::DP7_READY);
      case (state_q)
        // Idle released once our COMWAKE is out
        sata_oob_pkg::DP5_COMWAKE: begin
          if (com_done_i) begin
            elec_idle_q <= 1'b0;
          end
        end
        sata_oob_pkg::DP6_SEND_ALIGN: elec_idle_q <= 1'b0;
        sata_oob_pkg::DP7_READY:      elec_idle_q <= 1'b0;
        default:                      elec_idle_q <= 1'b1;
      endcase
      case (state_q)
        sata_oob_pkg::DP6_SEND_ALIGN: begin
          tx_q <= '{data: sata_prim_pkg::ALIGN_VAL, charisk: sata_prim_pkg::PRIM_CHARISK};
        end
        sata_oob_pkg::DP7_READY: begin
          tx_q <= '{data: sata_prim_pkg::SYNC_VAL, charisk: sata_prim_pkg::PRIM_CHARISK};
        end
        default: tx_q <= '0;
      endcase
    end
  end

  assign tx_elec_idle_o = elec_idle_q;
  assign link_up_o      = link_up_q;
  assign tx_o           = tx_q;

  // Ready is left only through a host COMRESET
  a_link_up_ready: assert property (@(posedge clk_phy) disable iff (!rst_n)
    link_up_o |-> ((state_q == sata_oob_pkg::DP7_READY) ||
                   $past(det_i.comreset_det)));

endmodule

/* verilog/sata_phy_dev_top.sv */
////////////////////
// SATA device PHY OOB top level
// Detector, burst generator, control block
////////////////////

`timescale 1ns/10ps

module sata_phy_dev_top #(
  parameter int SATA_REV     = 1,
  // 75 MHz cycle counts, doubled per revision step
  parameter int BURST_LEN    = 8 << (SATA_REV - 1),
  parameter int GAP_INIT     = 24 << (SATA_REV - 1),
  parameter int GAP_WAKE     = 8 << (SATA_REV - 1),
  parameter int GAP_TOL      = 2 << (SATA_REV - 1),
  // 10 ms retry and 55 us ALIGN timeouts
  parameter int RETRY_CYCLES = 750000 << (SATA_REV - 1),
  parameter int ALIGN_CYCLES = 4095 << (SATA_REV - 1)
) (
  input  logic                     clk_phy,
  input  logic                     rst_n,
  input  logic                     gt_rst_done_i,
  input  logic                     rx_oob_i,
  input  sata_prim_pkg::dword_t    rx_data_i,
  output logic                     tx_oob_o,
  output logic                     tx_elec_idle_o,
  output sata_prim_pkg::tx_dword_t tx_o,
  output logic                     link_up_o
);

  sata_oob_pkg::oob_det_t oob_det;
  sata_oob_pkg::com_req_t com_req;
  logic                   com_done;

  // Host COM recognition
  sata_oob_detect #(
    .GAP_INIT (GAP_INIT),
    .GAP_WAKE (GAP_WAKE),
    .GAP_TOL  (GAP_TOL)
  ) u_detect (
    .clk_phy  (clk_phy),
    .rst_n    (rst_n),
    .rx_oob_i (rx_oob_i),
    .det_o    (oob_det)
  );

  // Device COM trains
  sata_oob_burst_gen #(
    .BURST_LEN (BURST_LEN),
    .GAP_INIT  (GAP_INIT),
    .GAP_WAKE  (GAP_WAKE)
  ) u_burst_gen (
    .clk_phy  (clk_phy),
    .rst_n    (rst_n),
    .req_i    (com_req),
    .tx_oob_o (tx_oob_o),
    .done_o   (com_done)
  );

  // Bring-up sequencing
  sata_phy_dev_ctrl #(
    .RETRY_CYCLES (RETRY_CYCLES),
    .ALIGN_CYCLES (ALIGN_CYCLES)
  ) u_ctrl (
    .clk_phy        (clk_phy),
    .rst_n          (rst_n),
    .gt_rst_done_i  (gt_rst_done_i),
    .det_i          (oob_det),
    .rx_data_i      (rx_data_i),
    .com_done_i     (com_done),
    .com_req_o      (com_req),
    .tx_elec_idle_o (tx_elec_idle_o),
    .tx_o           (tx_o),
    .link_up_o      (link_up_o)
  );

endmodule

/* tests/tb_sata_checker.sv */
////////////////////
// Testbench monitor for the device PHY
// Burst and gap measurement of tx_oob_o
// Line output consistency, row expectations
// Error count
////////////////////

`timescale 1ns/10ps

module tb_sata_checker #(
  parameter int BURST_LEN = 4,
  parameter int GAP_INIT  = 24
) (
  input  logic                     clk_phy,
  input  logic                     rst_n,
  input  logic                     tx_oob_i,
  input  logic                     tx_elec_idle_i,
  input  sata_prim_pkg::tx_dword_t tx_i,
  input  logic                     link_up_i,
  input  int                       exp_gap_i,
  input  logic                     chk_stb_i,
  input  logic                     exp_link_i,
  input  logic                     exp_idle_i,
  input  sata_prim_pkg::tx_dword_t exp_tx_i,
  output int                       train_cnt_o,
  output int                       err_cnt_o
);

  localparam sata_prim_pkg::tx_dword_t SYNC_WORD =
    '{data: sata_prim_pkg::SYNC_VAL, charisk: sata_prim_pkg::PRIM_CHARISK};

  // Quiet this long after a burst closes a train
  localparam int TRAIN_END = GAP_INIT + 4;

  int   train_cnt = 0;
  int   err_cnt   = 0;
  logic oob_q;
  int   hi_len;
  int   lo_len;
  int   bursts;
  logic in_train;

  task automatic report(input string msg);
    err_cnt++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  always @(posedge clk_phy) begin
    if (!rst_n) begin
      oob_q    = 1'b0;
      hi_len   = 0;
      lo_len   = 0;
      bursts   = 0;
      in_train = 1'b0;
    end else begin
      ////////////////////
      // Burst train shape
      ////////////////////
      if (tx_oob_i) begin
        if (!oob_q) begin
          if (in_train && (lo_len != exp_gap_i)) begin
            report($sformatf("gap of %0d cycles, expected %0d", lo_len, exp_gap_i));
          end
          if (!in_train) begin
            in_train = 1'b1;
            bursts   = 0;
          end
          bursts++;
          hi_len = 0;
        end
        hi_len++;
        lo_len = 0;
      end else begin
        if (oob_q && (hi_len != BURST_LEN)) begin
          report($sformatf("burst of %0d cycles, expected %0d", hi_len, BURST_LEN));
        end
        lo_len++;
        if (in_train && (lo_len == TRAIN_END)) begin
          if (bursts != sata_oob_pkg::OOB_BURSTS) begin
            report($sformatf("train of %0d bursts, expected %0d", bursts,
                             sata_oob_pkg::OOB_BURSTS));
          end
          train_cnt++;
          in_train = 1'b0;
        end
      end
      oob_q = tx_oob_i;
      // Always true of the line outputs
      if (tx_oob_i && !tx_elec_idle_i) begin
        report("burst sent while electrical idle is low");
      end
      if (link_up_i && (tx_i != SYNC_WORD)) begin
        report($sformatf("link up but tx_o is %09h", tx_i));
      end
      // Row expectation on request
      if (chk_stb_i) begin
        if (link_up_i != exp_link_i) begin
          report($sformatf("link_up_o %0b, expected %0b", link_up_i, exp_link_i));
        end
        if (tx_elec_idle_i != exp_idle_i) begin
          report($sformatf("tx_elec_idle_o %0b, expected %0b", tx_elec_idle_i, exp_idle_i));
        end
        if (tx_i != exp_tx_i) begin
          report($sformatf("tx_o %09h, expected %09h", tx_i, exp_tx_i));
        end
      end
    end
  end

  assign train_cnt_o = train_cnt;
  assign err_cnt_o   = err_cnt;

endmodule

/* tests/tb_sata_phy_dev.sv */
////////////////////
// Testbench top for the SATA device PHY
// Clock, reset, host OOB model, LFSR jitter
// Scenario table applied in a loop
////////////////////

`timescale 1ns/10ps

module tb_sata_phy_dev;

  localparam int BURST_LEN    = 4;
  localparam int GAP_INIT     = 24;
  localparam int GAP_WAKE     = 8;
  localparam int GAP_TOL      = 2;
  localparam int RETRY_CYCLES = 600;
  localparam int ALIGN_CYCLES = 200;
  localparam int NUM_ROWS     = 5;
  // One COMINIT train with its trailing gap
  localparam int TRAIN_CYCLES = sata_oob_pkg::OOB_BURSTS * (BURST_LEN + GAP_INIT);

  localparam sata_prim_pkg::tx_dword_t ALIGN_WORD =
    '{data: sata_prim_pkg::ALIGN_VAL, charisk: sata_prim_pkg::PRIM_CHARISK};
  localparam sata_prim_pkg::tx_dword_t SYNC_WORD =
    '{data: sata_prim_pkg::SYNC_VAL, charisk: sata_prim_pkg::PRIM_CHARISK};

  typedef enum int {OUT_LINK, OUT_LINK_RESET, OUT_ALIGN_TO, OUT_RETRY_TO, OUT_NO_RESP} outcome_e;

  // Host reset gap, host wake gap (0 for none), host answers ALIGN, outcome
  typedef struct {
    int       reset_gap;
    int       wake_gap;
    bit       answer_align;
    outcome_e outcome;
  } row_t;

  logic                     clk_phy;
  logic                     rst_n;
  logic                     gt_rst_done;
  logic                     rx_oob;
  sata_prim_pkg::dword_t    rx_data;
  logic                     tx_oob;
  logic                     tx_idle;
  sata_prim_pkg::tx_dword_t tx;
  logic                     link_up;
  int                       exp_gap;
  logic                     chk_stb;
  logic                     exp_link;
  logic                     exp_idle;
  sata_prim_pkg::tx_dword_t exp_tx;
  int                       train_cnt;
  int                       chk_errs;
  int                       seq_errs    = 0;
  int                       trains_seen = 0;
  bit                       timed_out   = 1'b0;
  logic [31:0]              lfsr_q      = 32'h049fe273;
  row_t                     rows [NUM_ROWS];

  initial begin
    clk_phy = 1'b0;
    forever #50 clk_phy = ~clk_phy;
  end

  sata_phy_dev_top #(
    .BURST_LEN (BURST_LEN), .GAP_INIT (GAP_INIT), .GAP_WAKE (GAP_WAKE), .GAP_TOL (GAP_TOL),
    .RETRY_CYCLES (RETRY_CYCLES), .ALIGN_CYCLES (ALIGN_CYCLES)
  ) i_dut (
    .clk_phy (clk_phy), .rst_n (rst_n), .gt_rst_done_i (gt_rst_done), .rx_oob_i (rx_oob),
    .rx_data_i (rx_data), .tx_oob_o (tx_oob), .tx_elec_idle_o (tx_idle), .tx_o (tx),
    .link_up_o (link_up)
  );

  tb_sata_checker #(.BURST_LEN (BURST_LEN), .GAP_INIT (GAP_INIT)) i_checker (
    .clk_phy (clk_phy), .rst_n (rst_n), .tx_oob_i (tx_oob), .tx_elec_idle_i (tx_idle),
    .tx_i (tx), .link_up_i (link_up), .exp_gap_i (exp_gap), .chk_stb_i (chk_stb),
    .exp_link_i (exp_link), .exp_idle_i (exp_idle), .exp_tx_i (exp_tx),
    .train_cnt_o (train_cnt), .err_cnt_o (chk_errs)
  );

  // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic int rand_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  task automatic flag_timeout(input string msg);
    $display("%s", msg);
    timed_out = 1'b1;
  endtask

  task automatic seq_error(input string msg);
    seq_errs++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  ////////////////////
  // Host OOB model
  ////////////////////

  // Six bursts with each gap jittered by up to GAP_TOL
  task automatic send_com(input int gap);
    int g;
    @(posedge clk_phy);
    for (int b = 0; b < sata_oob_pkg::OOB_BURSTS; b++) begin
      g = gap + (rand_bits(3) % (2 * GAP_TOL + 1)) - GAP_TOL;
      rx_oob <= 1'b1;
      repeat (BURST_LEN) @(posedge clk_phy);
      rx_oob <= 1'b0;
      repeat (g) @(posedge clk_phy);
    end
  endtask

  // Next complete DUT train while the link stays down
  task automatic wait_train(input int limit, output int elapsed);
    bit warned;
    elapsed = 0;
    warned  = 1'b0;
    while ((train_cnt == trains_seen) && !timed_out) begin
      @(negedge clk_phy);
      elapsed++;
      if (link_up && !warned) begin
        seq_error("link_up_o high while waiting for a COM train");
        warned = 1'b1;
      end
      if (elapsed > limit) flag_timeout("Timeout: no COM train from the DUT");
    end
    trains_seen = train_cnt;
  endtask

  task automatic wait_link_up(input int limit);
    int n;
    n = 0;
    while (!link_up && !timed_out) begin
      @(negedge clk_phy);
      n++;
      if (n > limit) flag_timeout("Timeout: link_up_o never rose after host ALIGN");
    end
  endtask

  task automatic expect_line(input logic link, input logic idle,
                             input sata_prim_pkg::tx_dword_t word);
    @(posedge clk_phy);
    exp_link <= link;
    exp_idle <= idle;
    exp_tx   <= word;
    chk_stb  <= 1'b1;
    @(posedge clk_phy);
    chk_stb  <= 1'b0;
  endtask

  ////////////////////
  // One scenario row
  ////////////////////

  // Timeout windows open up to one gap before the wait starts
  task automatic run_row(input row_t row);
    int elapsed;
    @(posedge clk_phy);
    rst_n   <= 1'b0;
    rx_data <= '0;
    exp_gap <= GAP_INIT;
    repeat (4) @(posedge clk_phy);
    rst_n       <= 1'b1;
    gt_rst_done <= 1'b1;
    // DUT opens with its own COMINIT
    wait_train(400, elapsed);
    if (timed_out) return;
    send_com(row.reset_gap);
    if (row.outcome == OUT_NO_RESP) begin
      for (int i = 0; i < 150; i++) begin
        @(negedge clk_phy);
        if (tx_oob) seq_error("burst sent after an out-of-window host train");
      end
      if (train_cnt != trains_seen) seq_error("COMINIT answered an invalid COMRESET");
      return;
    end
    wait_train(400, elapsed);
    if (timed_out) return;
    if (row.outcome == OUT_RETRY_TO) begin
      wait_train(RETRY_CYCLES + 400, elapsed);
      if (elapsed < RETRY_CYCLES + TRAIN_CYCLES - GAP_INIT) begin
        seq_error("COMINIT retry came before the retry timeout");
      end
      return;
    end
    exp_gap <= GAP_WAKE;
    send_com(row.wake_gap);
    wait_train(400, elapsed);
    if (timed_out) return;
    exp_gap <= GAP_INIT;
    expect_line(1'b0, 1'b0, ALIGN_WORD);
    if (!row.answer_align) begin
      wait_train(ALIGN_CYCLES + 400, elapsed);
      if (elapsed < ALIGN_CYCLES + TRAIN_CYCLES - GAP_INIT) begin
        seq_error("COMINIT came before the ALIGN timeout");
      end
      return;
    end
    @(posedge clk_phy);
    rx_data <= sata_prim_pkg::ALIGN_VAL;
    wait_link_up(50);
    if (timed_out) return;
    expect_line(1'b1, 1'b0, SYNC_WORD);
    if (row.outcome == OUT_LINK_RESET) begin
      rx_data <= '0;
      send_com(GAP_INIT);
      wait_train(400, elapsed);
      if (timed_out) return;
      expect_line(1'b0, 1'b1, '0);
    end
  endtask

  initial begin
    rst_n       <= 1'b0;
    gt_rst_done <= 1'b0;
    rx_oob      <= 1'b0;
    rx_data     <= '0;
    exp_gap     <= GAP_INIT;
    chk_stb     <= 1'b0;
    exp_link    <= 1'b0;
    exp_idle    <= 1'b1;
    exp_tx      <= '0;
    rows[0] = '{GAP_INIT, GAP_WAKE, 1'b1, OUT_LINK};
    rows[1] = '{GAP_INIT, GAP_WAKE, 1'b0, OUT_ALIGN_TO};
    rows[2] = '{GAP_INIT, 0, 1'b0, OUT_RETRY_TO};
    rows[3] = '{16, GAP_WAKE, 1'b1, OUT_NO_RESP};
    rows[4] = '{GAP_INIT, GAP_WAKE, 1'b1, OUT_LINK_RESET};
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (!timed_out) begin
        run_row(rows[r]);
      end
    end
    repeat (4) @(posedge clk_phy);
    $display("Errors: checker %0d, sequence %0d", chk_errs, seq_errs);
    if (!timed_out && ((chk_errs + seq_errs) == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/sata_prim_pkg.sv
verilog/sata_oob_pkg.sv
verilog/sata_oob_detect.sv
verilog/sata_oob_burst_gen.sv
verilog/sata_phy_dev_ctrl.sv
verilog/sata_phy_dev_top.sv
tests/tb_sata_checker.sv
tests/tb_sata_phy_dev.sv

/* run.sh */
#!/bin/sh
# Build and run the SATA device PHY OOB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_sata_phy_dev -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# Pass only when the testbench reports it
echo "$out" | grep -q "Test passed"
